//--- Makefile
# Verilator simulation of the NVMe host link

VERILATOR ?= verilator
TOP       ?= tb_nvme_host
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/doorbell_writer.sv
`timescale 1ns/1ps
`include "nvme_host_cfg.svh"

module doorbell_writer (
  input  logic                      user_clk,
  input  logic                      user_reset,
  input  logic                      db_write_valid,
  input  nvme_host_pkg::db_write_t  db_write,
  input  logic                      grant,
  output logic                      req_valid,
  output nvme_host_pkg::rq_req_t    req,
  output logic                      db_drop
);
  import nvme_host_pkg::*;

  localparam int DEPTH = `NVME_DB_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  db_write_t          fifo_mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign push  = db_write_valid && !full;
  assign pop   = grant && !empty;   // Grant always refers to the head entry

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      db_drop <= 1'b0;
    end else begin
      db_drop <= db_write_valid && full;   // No room, write is lost
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge user_clk) begin
    if (push) fifo_mem[wr_ptr] <= db_write;
  end

  // Head entry as a posted write
  assign req_valid = !empty;
  assign req       = '{kind: MEM_WR,
                       addr: fifo_mem[rd_ptr].addr,
                       data: fifo_mem[rd_ptr].data,
                       tag:  tag_t'(0)};

endmodule

//--- design/host_controller.sv
`timescale 1ns/1ps
`include "nvme_host_cfg.svh"

module host_controller (
  input  logic                      user_clk,
  input  logic                      user_reset,
  input  logic                      user_lnk_up,
  input  logic                      db_cmd_valid,
  input  nvme_host_pkg::db_cmd_t    db_cmd,
  input  logic                      cfg_done,
  output logic                      start_config,
  output logic                      host_ready,
  output logic                      db_write_valid,
  output nvme_host_pkg::db_write_t  db_write
);
  import nvme_host_pkg::*;

  ctl_state_e               state;
  logic [$bits(qid_t):0]    db_index;   // 2 * qid + is_cq
  addr_t                    db_addr;

  // ----------------------------------------------------------------------
  // Link-up sequencing
  // ----------------------------------------------------------------------

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state        <= CTL_IDLE;
      start_config <= 1'b0;
    end else begin
      start_config <= 1'b0;
      if (!user_lnk_up) begin
        state <= CTL_IDLE;
      end else begin
        case (state)
          CTL_IDLE: begin
            state        <= CTL_CONFIG;
            start_config <= 1'b1;   // One pulse on entry
          end
          CTL_CONFIG: if (cfg_done) state <= CTL_READY;
          CTL_READY:  state <= CTL_READY;
          default:    state <= CTL_IDLE;
        endcase
      end
    end
  end

  assign host_ready = (state == CTL_READY);

  // ----------------------------------------------------------------------
  // Doorbell address formation
  // ----------------------------------------------------------------------

  // SQ tail and CQ head doorbells interleave per queue
  assign db_index = {db_cmd.qid, db_cmd.is_cq};
  assign db_addr  = addr_t'(`NVME_BAR0_BASE) + addr_t'(`NVME_DB_OFFSET)
                  + addr_t'(db_index) * addr_t'(`NVME_DB_STRIDE);

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      db_write_valid <= 1'b0;
    end else begin
      db_write_valid <= db_cmd_valid && host_ready;   // Dropped silently otherwise
    end
  end

  always_ff @(posedge user_clk) begin
    if (db_cmd_valid) begin
      db_write.addr <= db_addr;
      db_write.data <= data_t'(db_cmd.ptr);   // Zero extended
    end
  end

endmodule

//--- design/nvme_host_pkg.sv
package nvme_host_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  tag_t;
  typedef logic [3:0]  qid_t;
  typedef logic [15:0] qptr_t;
  typedef logic [2:0]  cpl_status_t;   // Zero is successful completion

  typedef enum logic {
    CFG_WR,
    MEM_WR
  } req_kind_e;

  // One beat on the outgoing request bus
  typedef struct packed {
    req_kind_e kind;
    addr_t     addr;
    data_t     data;
    tag_t      tag;
  } rq_req_t;

  // One beat on the completion bus
  typedef struct packed {
    tag_t        tag;
    cpl_status_t status;
    data_t       data;
  } rc_cpl_t;

  typedef struct packed {
    logic  is_cq;   // Completion queue head when set, else SQ tail
    qid_t  qid;
    qptr_t ptr;
  } db_cmd_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } db_write_t;

  typedef enum logic [1:0] {
    CTL_IDLE,
    CTL_CONFIG,
    CTL_READY
  } ctl_state_e;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_REQ,
    CFG_WAIT,
    CFG_FAIL
  } cfg_state_e;

endpackage

//--- design/nvme_host_top.sv
`timescale 1ns/1ps

module nvme_host_top (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  logic                    user_lnk_up,
  input  logic                    db_cmd_valid,
  input  nvme_host_pkg::db_cmd_t  db_cmd,
  input  logic                    rc_valid,
  input  nvme_host_pkg::rc_cpl_t  rc,
  output logic                    rq_valid,
  output nvme_host_pkg::rq_req_t  rq,
  output logic                    host_ready,
  output logic                    cfg_error,
  output logic                    db_drop
);
  import nvme_host_pkg::*;

  // Controller <-> configurator
  logic       start_config;
  logic       cfg_done;

  // Controller -> doorbell writer
  logic       db_write_valid;
  db_write_t  db_write;

  // Requesters <-> arbiter
  logic       cfg_req_valid;
  rq_req_t    cfg_req;
  logic       cfg_grant;
  logic       db_req_valid;
  rq_req_t    db_req;
  logic       db_grant;

  host_controller host_controller_inst (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .user_lnk_up    (user_lnk_up),
    .db_cmd_valid   (db_cmd_valid),
    .db_cmd         (db_cmd),
    .cfg_done       (cfg_done),
    .start_config   (start_config),
    .host_ready     (host_ready),
    .db_write_valid (db_write_valid),
    .db_write       (db_write)
  );

  pcie_configurator pcie_configurator_inst (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .user_lnk_up  (user_lnk_up),
    .start_config (start_config),
    .rc_valid     (rc_valid),
    .rc           (rc),
    .grant        (cfg_grant),
    .req_valid    (cfg_req_valid),
    .req          (cfg_req),
    .cfg_done     (cfg_done),
    .cfg_error    (cfg_error)
  );

  doorbell_writer doorbell_writer_inst (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .db_write_valid (db_write_valid),
    .db_write       (db_write),
    .grant          (db_grant),
    .req_valid      (db_req_valid),
    .req            (db_req),
    .db_drop        (db_drop)
  );

  rq_arbiter rq_arbiter_inst (
    .user_clk      (user_clk),
    .user_reset    (user_reset),
    .cfg_req_valid (cfg_req_valid),
    .cfg_req       (cfg_req),
    .db_req_valid  (db_req_valid),
    .db_req        (db_req),
    .cfg_grant     (cfg_grant),
    .db_grant      (db_grant),
    .rq_valid      (rq_valid),
    .rq            (rq)
  );

endmodule

//--- design/pcie_configurator.sv
`timescale 1ns/1ps
`include "nvme_host_cfg.svh"

module pcie_configurator (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  logic                    user_lnk_up,
  input  logic                    start_config,
  input  logic                    rc_valid,
  input  nvme_host_pkg::rc_cpl_t  rc,
  input  logic                    grant,
  output logic                    req_valid,
  output nvme_host_pkg::rq_req_t  req,
  output logic                    cfg_done,
  output logic                    cfg_error
);
  import nvme_host_pkg::*;

  localparam int STEP_W = (`NVME_CFG_STEPS > 1) ? $clog2(`NVME_CFG_STEPS) : 1;
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`NVME_CFG_STEPS - 1);

  // Script ROM
  localparam addr_t CFG_REGS [`NVME_CFG_STEPS] = '{
    `NVME_CFG_REG0,
    `NVME_CFG_REG1,
    `NVME_CFG_REG2
  };
  localparam data_t CFG_DATA [`NVME_CFG_STEPS] = '{
    `NVME_CFG_DATA0,
    `NVME_CFG_DATA1,
    `NVME_CFG_DATA2
  };

  cfg_state_e           state;
  logic [STEP_W-1:0]    step;
  logic                 cpl_hit;

  // Completions for other tags are not ours
  assign cpl_hit = rc_valid && (rc.tag == tag_t'(step));

  // ----------------------------------------------------------------------
  // Script walker
  // ----------------------------------------------------------------------

  always_ff @(posedge user_clk) begin
    if (user_reset || !user_lnk_up) begin
      state     <= CFG_IDLE;
      step      <= '0;
      cfg_done  <= 1'b0;
      cfg_error <= 1'b0;
    end else begin
      cfg_done <= 1'b0;
      case (state)
        CFG_IDLE: begin
          if (start_config) begin
            step  <= '0;
            state <= CFG_REQ;
          end
        end
        CFG_REQ: if (grant) state <= CFG_WAIT;   // Request is on rq now
        CFG_WAIT: begin
          if (cpl_hit) begin
            if (rc.status != '0) begin
              state     <= CFG_FAIL;
              cfg_error <= 1'b1;
            end else if (step == LAST_STEP) begin
              state    <= CFG_IDLE;
              cfg_done <= 1'b1;
            end else begin
              step  <= step + 1'b1;
              state <= CFG_REQ;
            end
          end
        end
        CFG_FAIL: state <= CFG_FAIL;   // Held until the link drops
        default:  state <= CFG_IDLE;
      endcase
    end
  end

  // Held until granted, tag is the step index
  assign req_valid = (state == CFG_REQ);
  assign req       = '{kind: CFG_WR,
                       addr: CFG_REGS[step],
                       data: CFG_DATA[step],
                       tag:  tag_t'(step)};

endmodule

//--- design/rq_arbiter.sv
`timescale 1ns/1ps

module rq_arbiter (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  logic                    cfg_req_valid,
  input  nvme_host_pkg::rq_req_t  cfg_req,
  input  logic                    db_req_valid,
  input  nvme_host_pkg::rq_req_t  db_req,
  output logic                    cfg_grant,
  output logic                    db_grant,
  output logic                    rq_valid,
  output nvme_host_pkg::rq_req_t  rq
);
  import nvme_host_pkg::*;

  logic cfg_pick;
  logic db_pick;

  // A port granted last cycle still shows the request it just got through
  assign cfg_pick = cfg_req_valid && !cfg_grant;
  assign db_pick  = db_req_valid && !db_grant && !cfg_pick;   // Configurator first

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      cfg_grant <= 1'b0;
      db_grant  <= 1'b0;
      rq_valid  <= 1'b0;
    end else begin
      cfg_grant <= cfg_pick;
      db_grant  <= db_pick;
      rq_valid  <= cfg_pick || db_pick;
    end
  end

  // Bus payload
  always_ff @(posedge user_clk) begin
    if (cfg_pick) begin
      rq <= cfg_req;
    end else if (db_pick) begin
      rq <= db_req;
    end
  end

endmodule

//--- include/nvme_host_cfg.svh
`ifndef NVME_HOST_CFG_SVH
`define NVME_HOST_CFG_SVH

// ----------------------------------------------------------------------
// Endpoint memory map
// ----------------------------------------------------------------------

`define NVME_BAR0_BASE      32'hF000_0000
`define NVME_DB_OFFSET      32'h0000_1000   // Doorbell block inside BAR0
`define NVME_DB_STRIDE      32'd4           // Bytes between doorbells

// ----------------------------------------------------------------------
// Config space script, one write per step
// ----------------------------------------------------------------------

`define NVME_CFG_STEPS      3

`define NVME_CFG_REG0       32'h0000_0010   // BAR0
`define NVME_CFG_DATA0      `NVME_BAR0_BASE
`define NVME_CFG_REG1       32'h0000_0014   // Upper dword of 64-bit BAR0
`define NVME_CFG_DATA1      32'h0000_0000
`define NVME_CFG_REG2       32'h0000_0004   // Command register
`define NVME_CFG_DATA2      32'h0000_0006   // Memory space + bus master enable

`define NVME_DB_FIFO_DEPTH  4

`endif

//--- tb.f
+incdir+include
design/nvme_host_pkg.sv
design/host_controller.sv
design/pcie_configurator.sv
design/doorbell_writer.sv
design/rq_arbiter.sv
design/nvme_host_top.sv
test/nvme_host_chk.sv
test/tb_nvme_host.sv

//--- test/nvme_host_chk.sv
`timescale 1ns/1ps

module nvme_host_chk (
  input logic                    user_clk,
  input logic                    user_reset,
  input logic                    rq_valid,
  input nvme_host_pkg::rq_req_t  rq,
  input logic                    host_ready,
  input logic                    cfg_error
);
  import nvme_host_pkg::*;

  int unsigned fail_count = 0;

  // Doorbells only go out on a configured link
  mem_wr_needs_ready: assert property (@(posedge user_clk) disable iff (user_reset)
    rq_valid && rq.kind == MEM_WR |-> host_ready)
  else begin
    fail_count++;
    $error("MEM_WR on rq while host_ready is low");
  end

  ready_excludes_error: assert property (@(posedge user_clk) disable iff (user_reset)
    !(host_ready && cfg_error))
  else begin
    fail_count++;
    $error("host_ready and cfg_error high together");
  end

  rq_idle_after_reset: assert property (@(posedge user_clk)
    user_reset |=> !rq_valid)
  else begin
    fail_count++;
    $error("rq_valid high in the cycle after reset");
  end

endmodule

bind nvme_host_top nvme_host_chk chk_inst (
  .user_clk   (user_clk),
  .user_reset (user_reset),
  .rq_valid   (rq_valid),
  .rq         (rq),
  .host_ready (host_ready),
  .cfg_error  (cfg_error)
);

//--- test/tb_nvme_host.sv
`timescale 1ns/1ps
`include "nvme_host_cfg.svh"

module tb_nvme_host;
  import nvme_host_pkg::*;

  localparam int N_EARLY     = 4;
  localparam int N_SPACED    = 24;
  localparam int N_BURSTS    = 6;
  localparam int MAX_BURST   = 12;
  localparam int CFG_LEN     = `NVME_CFG_STEPS * (8 + 6) + 10;
  localparam int SPACED_LEN  = N_SPACED * 7 + 20;
  localparam int BURST_LEN   = N_BURSTS * (MAX_BURST + 2 * `NVME_DB_FIFO_DEPTH + 16);
  localparam int CYCLE_LIMIT = 2 * (16 + 3 * CFG_LEN + 2 * SPACED_LEN + BURST_LEN + 80);

  logic     user_clk;
  logic     user_reset;
  logic     user_lnk_up;
  logic     db_cmd_valid;
  db_cmd_t  db_cmd;
  logic     rc_valid;
  rc_cpl_t  rc;
  logic     rq_valid;
  rq_req_t  rq;
  logic     host_ready;
  logic     cfg_error;
  logic     db_drop;

  // Reference model state
  addr_t        exp_reg  [`NVME_CFG_STEPS];
  data_t        exp_data [`NVME_CFG_STEPS];
  db_write_t    pend_q [$];   // Accepted commands still owed on rq
  string        test_name;
  int           errors;
  int           cycles;
  int           fail_step;    // Step whose completion carries bad status, -1 for none
  int           cfg_idx;
  int           cfg_ok;
  bit           cpl_wait;
  bit           strict;
  int           n_sent;
  int           n_written;
  int           n_dropped;

  nvme_host_top uut (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .user_lnk_up  (user_lnk_up),
    .db_cmd_valid (db_cmd_valid),
    .db_cmd       (db_cmd),
    .rc_valid     (rc_valid),
    .rc           (rc),
    .rq_valid     (rq_valid),
    .rq           (rq),
    .host_ready   (host_ready),
    .cfg_error    (cfg_error),
    .db_drop      (db_drop)
  );

  always #10 user_clk = ~user_clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge user_clk);
    #1;
  endtask

  task automatic check_value(input string field, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("ERROR [%s] %s: expected %h, actual %h", test_name, field, exp, act);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    assert (ok) else begin
      errors++;
      $display("Check failed in %s: %s", test_name, what);
    end
  endtask

  // Doorbell pair per queue, SQ tail first
  function automatic db_write_t expected_write(input db_cmd_t cmd);
    db_write_t w;
    w.addr = `NVME_BAR0_BASE + `NVME_DB_OFFSET
           + (2 * 32'(cmd.qid) + 32'(cmd.is_cq)) * `NVME_DB_STRIDE;
    w.data = {16'h0000, cmd.ptr};
    return w;
  endfunction

  task automatic clear_counts();
    n_sent    = 0;
    n_written = 0;
    n_dropped = 0;
    pend_q.delete();
  endtask

  // Leaves db_cmd_valid high, the caller ends the burst
  task automatic send_cmd();
    db_cmd_t cmd;
    cmd.is_cq    = 1'($urandom);
    cmd.qid      = qid_t'($urandom);
    cmd.ptr      = qptr_t'($urandom);
    db_cmd_valid = 1'b1;
    db_cmd       = cmd;
    if (host_ready) begin
      pend_q.push_back(expected_write(cmd));
      n_sent++;
    end
    next_cycle();
  endtask

  task automatic wait_drain();
    while (n_written + n_dropped < n_sent) next_cycle();
    repeat (6) next_cycle();   // Room for anything extra
  endtask

  // ----------------------------------------------------------------------
  // Endpoint model and bus monitor
  // ----------------------------------------------------------------------

  task automatic answer_cfg(input tag_t tag);
    int delay;
    delay = $urandom_range(8, 1);
    repeat (delay) @(posedge user_clk);
    #1;
    rc_valid  = 1'b1;
    rc.tag    = tag;
    rc.status = (int'(tag) == fail_step) ? cpl_status_t'($urandom_range(7, 1)) : '0;
    rc.data   = '0;
    @(posedge user_clk);
    #1;
    rc_valid = 1'b0;
  endtask

  initial begin : endpoint
    forever begin
      @(negedge user_clk);
      if (rq_valid && rq.kind == CFG_WR) answer_cfg(rq.tag);
    end
  end

  task automatic record_cfg_write();
    check_cond(!cpl_wait, "CFG_WR issued before the previous completion arrived");
    check_cond(!cfg_error, "CFG_WR issued after a failed completion");
    if (cfg_idx >= `NVME_CFG_STEPS) begin
      check_cond(1'b0, "more CFG_WRs than script steps");
    end else begin
      check_value("cfg_addr", exp_reg[cfg_idx], rq.addr);
      check_value("cfg_data", exp_data[cfg_idx], rq.data);
      check_value("cfg_tag", cfg_idx, 32'(rq.tag));
      cfg_idx++;
    end
    cpl_wait = 1'b1;
  endtask

  task automatic record_mem_write();
    int        hit;
    db_write_t w;
    hit = -1;
    n_written++;
    check_value("db_tag", 0, 32'(rq.tag));
    if (pend_q.size() == 0) begin
      check_cond(1'b0, "MEM_WR on rq with no accepted doorbell command");
    end else if (strict) begin
      w = pend_q.pop_front();
      check_value("db_addr", w.addr, rq.addr);
      check_value("db_data", w.data, rq.data);
    end else begin
      // Entries skipped over were dropped
      for (int i = 0; i < pend_q.size(); i++) begin
        if (hit < 0 && pend_q[i].addr == rq.addr && pend_q[i].data == rq.data) hit = i;
      end
      check_cond(hit >= 0, "MEM_WR matches no pending doorbell command in order");
      repeat (hit + 1) void'(pend_q.pop_front());
    end
  endtask

  always @(negedge user_clk) begin
    if (!user_lnk_up) begin
      cfg_idx  = 0;
      cfg_ok   = 0;
      cpl_wait = 1'b0;
    end else if (host_ready) begin
      check_cond(cfg_ok == `NVME_CFG_STEPS, "host_ready rose before all config completions");
    end
    if (rc_valid && cpl_wait && rc.tag == tag_t'(cfg_idx - 1)) begin
      cpl_wait = 1'b0;
      if (rc.status == '0) cfg_ok++;
    end
    if (db_drop) n_dropped++;
    if (rq_valid && rq.kind == CFG_WR) record_cfg_write();
    if (rq_valid && rq.kind == MEM_WR) record_mem_write();
  end

  // ----------------------------------------------------------------------
  // Test phases
  // ----------------------------------------------------------------------

  // Early commands go out while config is still running
  task automatic bring_up();
    clear_counts();
    user_lnk_up = 1'b1;
    for (int i = 0; i < N_EARLY; i++) begin
      check_cond(!host_ready, "early command not sent before host_ready");
      send_cmd();
    end
    db_cmd_valid = 1'b0;
    while (!host_ready) next_cycle();
    repeat (4) next_cycle();
    check_value("cfg_writes", `NVME_CFG_STEPS, cfg_idx);
    check_value("early_writes", 0, n_written);
    check_value("early_drops", 0, n_dropped);
  endtask

  task automatic drop_link();
    user_lnk_up = 1'b0;
    repeat (2) next_cycle();
    check_cond(!host_ready, "host_ready still high after the link went down");
    check_cond(!cfg_error, "cfg_error still high after the link went down");
  endtask

  task automatic run_spaced();
    test_name = "spaced_cmds";
    clear_counts();
    strict = 1'b1;
    repeat (N_SPACED) begin
      send_cmd();
      db_cmd_valid = 1'b0;
      repeat ($urandom_range(5, 2)) next_cycle();   // 3 to 6 cycles apart
    end
    wait_drain();
    check_value("writes", n_sent, n_written);
    check_value("drops", 0, n_dropped);
  endtask

  task automatic run_bursts();
    test_name = "bursts";
    clear_counts();
    strict = 1'b0;
    repeat (N_BURSTS) begin
      repeat ($urandom_range(MAX_BURST, 6)) send_cmd();
      db_cmd_valid = 1'b0;
      wait_drain();
    end
    check_value("writes_plus_drops", n_sent, n_written + n_dropped);
  endtask

  task automatic run_cfg_error();
    test_name   = "cfg_error";
    fail_step   = $urandom_range(`NVME_CFG_STEPS - 1, 0);
    user_lnk_up = 1'b1;
    while (!cfg_error) next_cycle();
    check_value("writes_to_failure", fail_step + 1, cfg_idx);
    repeat (20) begin
      next_cycle();
      check_cond(!host_ready, "host_ready rose after a failed completion");
    end
    drop_link();
    fail_step = -1;
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge user_clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int total;
    void'($urandom(32'hfc8e));
    user_clk     = 1'b0;
    user_reset   = 1'b1;
    user_lnk_up  = 1'b0;
    db_cmd_valid = 1'b0;
    db_cmd       = '0;
    rc_valid     = 1'b0;
    rc           = '0;
    errors       = 0;
    fail_step    = -1;
    strict       = 1'b1;
    exp_reg      = '{`NVME_CFG_REG0, `NVME_CFG_REG1, `NVME_CFG_REG2};
    exp_data     = '{`NVME_CFG_DATA0, `NVME_CFG_DATA1, `NVME_CFG_DATA2};
    clear_counts();
    repeat (16) @(posedge user_clk);
    #1;
    user_reset = 1'b0;
    next_cycle();

    test_name = "config";
    bring_up();
    run_spaced();
    run_bursts();
    test_name = "relink";
    drop_link();
    bring_up();
    run_spaced();
    test_name = "cfg_error";
    drop_link();
    run_cfg_error();

    total = errors + uut.chk_inst.fail_count;
    $display("Run complete: %0d check errors, %0d assertion failures",
             errors, uut.chk_inst.fail_count);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
